// ==== periph_pkg.sv ====
//////////////////////////////////////////////////
// shared sizes, address map and encodings for the
// peripheral subsystem; referenced by scoped names
//////////////////////////////////////////////////

`default_nettype none

package periph_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////
  localparam int APB_ADDR_WIDTH = 32;
  localparam int APB_DATA_WIDTH = 32;

  localparam int NB_TIMER_CH = 4;  // pwm channels

  // region field of paddr, one region per target
  localparam int REGION_MSB = 11;
  localparam int REGION_LSB = 8;
  localparam logic [REGION_MSB-REGION_LSB:0] REGION_EVENT = 4'd4;  // 0..3 are channels

  // channel word offsets, paddr[3:2]
  localparam logic [1:0] REG_CTRL    = 2'd0;
  localparam logic [1:0] REG_PERIOD  = 2'd1;
  localparam logic [1:0] REG_COMPARE = 2'd2;
  localparam logic [1:0] REG_COUNT   = 2'd3;  // read only

  // event unit word offsets
  localparam logic [1:0] REG_PENDING = 2'd0;
  localparam logic [1:0] REG_MASK    = 2'd1;

  localparam int CNT_WIDTH = 16;

  //////////////////////////////////////////////////
  // fc event line positions
  //////////////////////////////////////////////////
  localparam int FC_EVT_WIDTH      = 32;
  localparam int FC_EVT_SUMMARY    = 11;
  localparam int FC_EVT_REF_RISE   = 18;
  localparam int FC_EVT_REF_FALL   = 19;
  localparam int FC_EVT_TIMER_BASE = 21;  // channels at 21..24

  // pending bits: channels, then ref rise, ref fall
  localparam int NB_PEND = NB_TIMER_CH + 2;

  // CTRL[1:0]
  typedef enum logic [1:0] {
    MODE_STOP    = 2'd0,
    MODE_FREE    = 2'd1,
    MODE_ONESHOT = 2'd2
  } timer_mode_e;

  // CTRL[2]
  typedef enum logic {
    CLKSRC_SYS = 1'b0,
    CLKSRC_REF = 1'b1
  } clk_src_e;

  typedef enum logic {
    APB_IDLE,
    APB_ACCESS
  } apb_state_e;

endpackage

`default_nettype wire

// ==== reg_bus_if.sv ====
//////////////////////////////////////////////////
// internal register port between the APB decoder
// and one register target (channel or event unit)
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if;

  logic                                  we;      // single-cycle write strobe
  logic                                  re;      // single-cycle read strobe
  logic [1:0]                            offset;  // word offset in the region
  logic [periph_pkg::APB_DATA_WIDTH-1:0] wdata;
  logic [periph_pkg::APB_DATA_WIDTH-1:0] rdata;   // zero outside a read

  // decoder side
  modport decoder (
    output we,
    output re,
    output offset,
    output wdata,
    input  rdata
  );

  // register block side
  modport target (
    input  we,
    input  re,
    input  offset,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// ==== periph_bus_decoder.sv ====
//////////////////////////////////////////////////
// APB slave, zero wait states; splits the region
// field into per-target strobes, muxes read data
// and flags unmapped regions with pslverr
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module periph_bus_decoder (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_i,
  input  wire logic [periph_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
  input  wire logic                                  psel_i,
  input  wire logic                                  penable_i,
  input  wire logic                                  pwrite_i,
  input  wire logic [periph_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
  output logic      [periph_pkg::APB_DATA_WIDTH-1:0] prdata_o,
  output logic                                       pslverr_o,
  reg_bus_if.decoder                                 ch_bus [periph_pkg::NB_TIMER_CH],
  reg_bus_if.decoder                                 evt_bus
);

  localparam int RW = periph_pkg::REGION_MSB - periph_pkg::REGION_LSB + 1;

  periph_pkg::apb_state_e state_q, state_d;

  logic [RW-1:0]                         region;
  logic [1:0]                            offset;
  logic [periph_pkg::NB_TIMER_CH-1:0]    ch_sel;     // one-hot channel select
  logic                                  evt_sel;
  logic                                  mapped;
  logic                                  access;     // apb access phase
  logic [periph_pkg::APB_DATA_WIDTH-1:0] ch_rdata [periph_pkg::NB_TIMER_CH];
  logic [periph_pkg::APB_DATA_WIDTH-1:0] rdata_mux;

  //////////////////////////////////////////////////
  // phase tracker
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      periph_pkg::APB_IDLE:   if (psel_i && !penable_i) state_d = periph_pkg::APB_ACCESS;
      periph_pkg::APB_ACCESS: state_d = periph_pkg::APB_IDLE;  // no wait states
      default:                state_d = periph_pkg::APB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= periph_pkg::APB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign access = (state_q == periph_pkg::APB_ACCESS) && psel_i && penable_i;

  //////////////////////////////////////////////////
  // region decode
  //////////////////////////////////////////////////
  assign region = paddr_i[periph_pkg::REGION_MSB:periph_pkg::REGION_LSB];
  assign offset = paddr_i[3:2];  // word aligned

  always_comb begin
    for (int i = 0; i < periph_pkg::NB_TIMER_CH; i++) begin
      ch_sel[i] = (region == RW'(i));
    end
  end

  assign evt_sel = (region == periph_pkg::REGION_EVENT);
  assign mapped  = |ch_sel || evt_sel;

  // strobes go only to the selected target
  for (genvar i = 0; i < periph_pkg::NB_TIMER_CH; i++) begin : g_ch
    assign ch_bus[i].we     = access && pwrite_i && ch_sel[i];
    assign ch_bus[i].re     = access && !pwrite_i && ch_sel[i];
    assign ch_bus[i].offset = offset;
    assign ch_bus[i].wdata  = pwdata_i;
    assign ch_rdata[i]      = ch_bus[i].rdata;
  end

  assign evt_bus.we     = access && pwrite_i && evt_sel;
  assign evt_bus.re     = access && !pwrite_i && evt_sel;
  assign evt_bus.offset = offset;
  assign evt_bus.wdata  = pwdata_i;

  //////////////////////////////////////////////////
  // read mux and error
  //////////////////////////////////////////////////
  always_comb begin
    rdata_mux = evt_sel ? evt_bus.rdata : '0;
    for (int i = 0; i < periph_pkg::NB_TIMER_CH; i++) begin
      if (ch_sel[i]) rdata_mux = ch_rdata[i];  // selects are one-hot
    end
  end

  // targets drive 0 outside a read, unmapped reads give 0
  assign prdata_o  = rdata_mux;
  assign pslverr_o = access && !mapped;

endmodule

`default_nettype wire

// ==== ref_clk_sync.sv ====
//////////////////////////////////////////////////
// brings the slow reference clock into the system
// clock domain, one-cycle pulse per edge
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ref_clk_sync (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic ref_clk_i,
  output logic      ref_rise_o,
  output logic      ref_fall_o
);

  logic sync_meta;  // first stage, may go metastable
  logic sync_q;     // settled sample
  logic hist_q;     // previous settled sample

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_meta  <= 1'b0;
      sync_q     <= 1'b0;
      hist_q     <= 1'b0;
      ref_rise_o <= 1'b0;
      ref_fall_o <= 1'b0;
    end else begin
      sync_meta  <= ref_clk_i;
      sync_q     <= sync_meta;
      hist_q     <= sync_q;
      ref_rise_o <= sync_q && !hist_q;  // 0 -> 1
      ref_fall_o <= !sync_q && hist_q;  // 1 -> 0
    end
  end

endmodule

`default_nettype wire

// ==== timer_channel.sv ====
//////////////////////////////////////////////////
// one pwm timer channel with CTRL, PERIOD, COMPARE
// and a read-only COUNT; ticks on system clock or
// reference rising edges, pulses evt_o on wrap
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module timer_channel (
  input  wire logic clk_i,
  input  wire logic rst_i,
  reg_bus_if.target bus,
  input  wire logic ref_rise_i,
  output logic      pwm_o,
  output logic      evt_o
);

  localparam int CW = periph_pkg::CNT_WIDTH;
  localparam int DW = periph_pkg::APB_DATA_WIDTH;

  periph_pkg::timer_mode_e mode_q;
  periph_pkg::clk_src_e    clk_src_q;

  logic [CW-1:0] period_q;
  logic [CW-1:0] compare_q;
  logic [CW-1:0] count_q;
  logic          running;
  logic          tick;
  logic          wrap;
  logic          ctrl_wr;

  assign running = (mode_q != periph_pkg::MODE_STOP);
  assign tick    = (clk_src_q == periph_pkg::CLKSRC_SYS) ? 1'b1 : ref_rise_i;
  assign wrap    = running && tick && (count_q == period_q);
  assign ctrl_wr = bus.we && (bus.offset == periph_pkg::REG_CTRL);

  //////////////////////////////////////////////////
  // config registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      period_q  <= '0;
      compare_q <= '0;
      clk_src_q <= periph_pkg::CLKSRC_SYS;
    end else if (bus.we) begin
      case (bus.offset)
        periph_pkg::REG_CTRL:    clk_src_q <= periph_pkg::clk_src_e'(bus.wdata[2]);
        periph_pkg::REG_PERIOD:  period_q  <= bus.wdata[CW-1:0];
        periph_pkg::REG_COMPARE: compare_q <= bus.wdata[CW-1:0];
        default: ;  // COUNT writes dropped
      endcase
    end
  end

  //////////////////////////////////////////////////
  // mode, counter, wrap event
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mode_q  <= periph_pkg::MODE_STOP;
      count_q <= '0;
      evt_o   <= 1'b0;
    end else begin
      evt_o <= wrap && !ctrl_wr;
      if (ctrl_wr) begin
        count_q <= '0;  // restart from zero on any CTRL write
        case (bus.wdata[1:0])
          periph_pkg::MODE_FREE:    mode_q <= periph_pkg::MODE_FREE;
          periph_pkg::MODE_ONESHOT: mode_q <= periph_pkg::MODE_ONESHOT;
          default:                  mode_q <= periph_pkg::MODE_STOP;  // 3 acts as stop
        endcase
      end else if (wrap) begin
        count_q <= '0;
        if (mode_q == periph_pkg::MODE_ONESHOT) mode_q <= periph_pkg::MODE_STOP;
      end else if (running && tick) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // high for COMPARE ticks of every period
  assign pwm_o = running && (count_q < compare_q);

  //////////////////////////////////////////////////
  // read back
  //////////////////////////////////////////////////
  always_comb begin
    bus.rdata = '0;
    if (bus.re) begin
      case (bus.offset)
        periph_pkg::REG_CTRL:    bus.rdata = {{(DW-3){1'b0}}, clk_src_q, mode_q};
        periph_pkg::REG_PERIOD:  bus.rdata = {{(DW-CW){1'b0}}, period_q};
        periph_pkg::REG_COMPARE: bus.rdata = {{(DW-CW){1'b0}}, compare_q};
        default:                 bus.rdata = {{(DW-CW){1'b0}}, count_q};
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== soc_event_unit.sv ====
//////////////////////////////////////////////////
// routes timer and ref clock pulses onto the fc
// event lines and keeps a sticky pending register
// whose unmasked bits form one summary event
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module soc_event_unit (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_i,
  reg_bus_if.target                                  bus,
  input  wire logic [periph_pkg::NB_TIMER_CH-1:0]    timer_evt_i,
  input  wire logic                                  ref_rise_i,
  input  wire logic                                  ref_fall_i,
  output logic      [periph_pkg::FC_EVT_WIDTH-1:0]   fc_events_o
);

  localparam int NP = periph_pkg::NB_PEND;
  localparam int DW = periph_pkg::APB_DATA_WIDTH;

  logic [NP-1:0] pending_q;
  logic [NP-1:0] mask_q;      // 1 enables the bit onto the summary
  logic [NP-1:0] pend_set;
  logic [NP-1:0] pend_clr;
  logic          summary_q;

  // bit order matches the pending register layout
  assign pend_set = {ref_fall_i, ref_rise_i, timer_evt_i};
  assign pend_clr = (bus.we && (bus.offset == periph_pkg::REG_PENDING)) ?
                    bus.wdata[NP-1:0] : '0;

  //////////////////////////////////////////////////
  // pending, mask, summary
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      mask_q    <= '0;
      summary_q <= 1'b0;
    end else begin
      pending_q <= (pending_q & ~pend_clr) | pend_set;  // set beats w1c
      summary_q <= |(pending_q & mask_q);
      if (bus.we && (bus.offset == periph_pkg::REG_MASK)) begin
        mask_q <= bus.wdata[NP-1:0];
      end
    end
  end

  // fixed positions, unused lines held low
  always_comb begin
    fc_events_o = '0;
    for (int i = 0; i < periph_pkg::NB_TIMER_CH; i++) begin
      fc_events_o[periph_pkg::FC_EVT_TIMER_BASE + i] = timer_evt_i[i];
    end
    fc_events_o[periph_pkg::FC_EVT_REF_RISE] = ref_rise_i;
    fc_events_o[periph_pkg::FC_EVT_REF_FALL] = ref_fall_i;
    fc_events_o[periph_pkg::FC_EVT_SUMMARY]  = summary_q;  // registered
  end

  always_comb begin
    bus.rdata = '0;
    if (bus.re) begin
      case (bus.offset)
        periph_pkg::REG_PENDING: bus.rdata = {{(DW-NP){1'b0}}, pending_q};
        periph_pkg::REG_MASK:    bus.rdata = {{(DW-NP){1'b0}}, mask_q};
        default: ;  // unused offsets read 0
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== soc_peripherals.sv ====
//////////////////////////////////////////////////
// peripheral subsystem top: APB register path,
// four pwm timers, ref clock edges, event routing
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module soc_peripherals (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_i,
  // apb slave
  input  wire logic [periph_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
  input  wire logic                                  psel_i,
  input  wire logic                                  penable_i,
  input  wire logic                                  pwrite_i,
  input  wire logic [periph_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
  output logic      [periph_pkg::APB_DATA_WIDTH-1:0] prdata_o,
  output logic                                       pslverr_o,
  // slow reference clock
  input  wire logic                                  ref_clk_i,
  // pwm pins and fc event lines
  output logic      [periph_pkg::NB_TIMER_CH-1:0]    apbio_out_o,
  output logic      [periph_pkg::FC_EVT_WIDTH-1:0]   fc_events_o
);

  reg_bus_if ch_bus [periph_pkg::NB_TIMER_CH] ();  // one per channel
  reg_bus_if evt_bus ();

  logic [periph_pkg::NB_TIMER_CH-1:0] timer_evt;
  logic                               ref_rise;
  logic                               ref_fall;

  //////////////////////////////////////////////////
  // register path
  //////////////////////////////////////////////////
  periph_bus_decoder u_decoder (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .ch_bus    (ch_bus),
    .evt_bus   (evt_bus)
  );

  ref_clk_sync u_ref_sync (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ref_clk_i  (ref_clk_i),
    .ref_rise_o (ref_rise),
    .ref_fall_o (ref_fall)
  );

  //////////////////////////////////////////////////
  // timers
  //////////////////////////////////////////////////
  for (genvar i = 0; i < periph_pkg::NB_TIMER_CH; i++) begin : g_ch
    timer_channel u_channel (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .bus        (ch_bus[i]),
      .ref_rise_i (ref_rise),
      .pwm_o      (apbio_out_o[i]),  // one pin per channel
      .evt_o      (timer_evt[i])
    );
  end

  soc_event_unit u_event (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus         (evt_bus),
    .timer_evt_i (timer_evt),
    .ref_rise_i  (ref_rise),
    .ref_fall_i  (ref_fall),
    .fc_events_o (fc_events_o)
  );

endmodule

`default_nettype wire

// ==== tb_apb_tasks.svh ====
//////////////////////////////////////////////////
// APB master tasks and check helpers for the
// peripheral testbench, included inside its module
//////////////////////////////////////////////////

`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// region in bits 11:8, word offset in bits 3:2
function automatic logic [31:0] reg_addr(input int region, input logic [1:0] off);
  logic [31:0] addr;
  addr = 32'(region) << periph_pkg::REGION_LSB;
  addr[3:2] = off;
  return addr;
endfunction

task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
  @(posedge clk);
  #2;
  paddr   = addr;  // setup phase
  pwdata  = data;
  pwrite  = 1'b1;
  psel    = 1'b1;
  penable = 1'b0;
  @(posedge clk);
  #2;
  penable = 1'b1;  // access phase
  @(posedge clk);  // write lands on this edge
  #2;
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
  @(posedge clk);
  #2;
  paddr   = addr;
  pwrite  = 1'b0;
  psel    = 1'b1;
  penable = 1'b0;
  @(posedge clk);
  #2;
  penable = 1'b1;
  @(negedge clk);  // mid access cycle, prdata settled
  data = prdata;
  err  = pslverr;
  @(posedge clk);
  #2;
  psel    = 1'b0;
  penable = 1'b0;
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic check_true(input bit cond, input string what);
  checks++;
  assert (cond) else begin
    errors++;
    $display("%s", what);
  end
endtask

// read one register, expect the value and no slave error
task automatic read_check(input string name, input logic [31:0] addr, input logic [31:0] exp);
  logic [31:0] data;
  logic        err;
  apb_read(addr, data, err);
  check_value(name, data, exp);
  check_true(!err, {name, " read got an unexpected slave error"});
endtask

`endif

// ==== tb_soc_peripherals.sv ====
//////////////////////////////////////////////////
// directed testbench for the peripheral subsystem
// APB register access, pwm timers, ref ticks, events
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_soc_peripherals;

  localparam int TIMEOUT_CYCLES = 5000;  // tests need under 1000 cycles
  localparam int REF_HALF       = 8;     // ref_clk toggles every 8 cycles
  localparam logic [31:0] REF_EVT_BITS = (32'd1 << periph_pkg::FC_EVT_REF_RISE) |
                                         (32'd1 << periph_pkg::FC_EVT_REF_FALL);

  logic        clk;
  logic        rst;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pslverr;
  logic        ref_clk;
  logic [3:0]  apbio_out;
  logic [31:0] fc_events;

  int errors    = 0;
  int checks    = 0;
  int cycles    = 0;
  int ref_div   = 0;
  int ref_rises = 0;  // rising edges put on ref_clk
  bit ref_en    = 1'b0;

  soc_peripherals u_soc_peripherals (
    .clk_i       (clk),
    .rst_i       (rst),
    .paddr_i     (paddr),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pslverr_o   (pslverr),
    .ref_clk_i   (ref_clk),
    .apbio_out_o (apbio_out),
    .fc_events_o (fc_events)
  );

  `include "tb_apb_tasks.svh"

  always #10 clk = ~clk;  // 20 ns period

  // slow reference clock, driven like any other input
  always begin
    @(posedge clk);
    #2;
    if (ref_en) begin
      ref_div = ref_div + 1;
      if (ref_div == REF_HALF) begin
        ref_div = 0;
        ref_clk = ~ref_clk;
        if (ref_clk) ref_rises++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, tests did not finish", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [31:0] ctrl_word(input periph_pkg::timer_mode_e mode,
                                            input periph_pkg::clk_src_e src);
    return {29'b0, src, mode};  // src in bit 2, mode in 1:0
  endfunction

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic test_reset_state();
    read_check("MASK", reg_addr(periph_pkg::REGION_EVENT, periph_pkg::REG_MASK), 0);
    read_check("PENDING", reg_addr(periph_pkg::REGION_EVENT, periph_pkg::REG_PENDING), 0);
    @(negedge clk);
    ref_en = 1'b1;  // ref edges may show on bits 18/19 from here on
    for (int ch = 0; ch < 4; ch++) begin
      for (int r = 0; r < 4; r++) begin
        read_check($sformatf("ch%0d reg%0d", ch, r), reg_addr(ch, 2'(r)), 0);
        @(negedge clk);
        check_value("apbio_out_o", 32'(apbio_out), 0);
        check_value("fc_events_o w/o ref bits", fc_events & ~REF_EVT_BITS, 0);
      end
    end
  endtask

  task automatic test_register_access();
    logic [31:0] data;
    logic        err;
    apb_write(reg_addr(1, periph_pkg::REG_CTRL),
              ctrl_word(periph_pkg::MODE_ONESHOT, periph_pkg::CLKSRC_REF));
    apb_write(reg_addr(1, periph_pkg::REG_PERIOD), 32'h1234);
    apb_write(reg_addr(1, periph_pkg::REG_COMPARE), 32'h0056);
    read_check("ch1 CTRL", reg_addr(1, periph_pkg::REG_CTRL), 32'h6);
    read_check("ch1 PERIOD", reg_addr(1, periph_pkg::REG_PERIOD), 32'h1234);
    read_check("ch1 COMPARE", reg_addr(1, periph_pkg::REG_COMPARE), 32'h0056);
    apb_write(reg_addr(1, periph_pkg::REG_CTRL),
              ctrl_word(periph_pkg::MODE_STOP, periph_pkg::CLKSRC_REF));  // stops and clears count
    apb_write(reg_addr(1, periph_pkg::REG_COUNT), 32'hbeef);  // read only
    read_check("ch1 CTRL", reg_addr(1, periph_pkg::REG_CTRL), 32'h4);
    read_check("ch1 COUNT", reg_addr(1, periph_pkg::REG_COUNT), 32'h0);
    apb_write(reg_addr(periph_pkg::REGION_EVENT, periph_pkg::REG_MASK), 32'h2a);
    read_check("MASK", reg_addr(periph_pkg::REGION_EVENT, periph_pkg::REG_MASK), 32'h2a);
    apb_write(reg_addr(periph_pkg::REGION_EVENT, periph_pkg::REG_MASK), 32'h0);
    apb_write(reg_addr(1, periph_pkg::REG_CTRL), 32'h0);
    apb_read(reg_addr(7, 2'd0), data, err);  // unmapped region
    check_value("region 7 prdata_o", data, 0);
    check_true(err, "read from unmapped region 7 did not raise pslverr_o");
  endtask

  task automatic test_free_pwm();
    int p;
    int c;
    int k;
    int high;
    int pulses;
    p = 9;
    c = 4;
    k = 5;
    high = 0;
    pulses = 0;
    apb_write(reg_addr(0, periph_pkg::REG_PERIOD), 32'(p));
    apb_write(reg_addr(0, periph_pkg::REG_COMPARE), 32'(c));
    apb_write(reg_addr(0, periph_pkg::REG_CTRL),
              ctrl_word(periph_pkg::MODE_FREE, periph_pkg::CLKSRC_SYS));
    repeat (k * (p + 1)) begin  // counter starts at 0 here
      @(negedge clk);
      if (apbio_out[0]) high++;
      if (fc_events[periph_pkg::FC_EVT_TIMER_BASE]) pulses++;
    end
    apb_write(reg_addr(0, periph_pkg::REG_CTRL), 32'h0);
    check_value("ch0 pwm high cycles", 32'(high), 32'(k * c));
    check_true(pulses >= k - 1 && pulses <= k + 1,
               $sformatf("ch0 gave %0d wrap events, expected about %0d", pulses, k));
  endtask

  task automatic test_oneshot();
    int pulses;
    int high;
    pulses = 0;
    high = 0;
    apb_write(reg_addr(2, periph_pkg::REG_PERIOD), 32'd5);
    apb_write(reg_addr(2, periph_pkg::REG_COMPARE), 32'd3);
    apb_write(reg_addr(2, periph_pkg::REG_CTRL),
              ctrl_word(periph_pkg::MODE_ONESHOT, periph_pkg::CLKSRC_SYS));
    repeat (18) begin  // three periods worth
      @(negedge clk);
      if (fc_events[periph_pkg::FC_EVT_TIMER_BASE + 2]) pulses++;
    end
    check_value("ch2 one-shot events", 32'(pulses), 1);
    read_check("ch2 CTRL", reg_addr(2, periph_pkg::REG_CTRL),
               ctrl_word(periph_pkg::MODE_STOP, periph_pkg::CLKSRC_SYS));
    repeat (10) begin
      @(negedge clk);
      if (apbio_out[2]) high++;
    end
    check_value("ch2 pwm high after stop", 32'(high), 0);
  endtask

  task automatic test_ref_tick_pending();
    int          rises0;
    int          edges;
    int          rise_evts;
    int          fall_evts;
    logic [31:0] data;
    logic        err;
    rise_evts = 0;
    fall_evts = 0;
    apb_write(reg_addr(3, periph_pkg::REG_PERIOD), 32'hffff);  // no wrap
    rises0 = ref_rises;
    apb_write(reg_addr(3, periph_pkg::REG_CTRL),
              ctrl_word(periph_pkg::MODE_FREE, periph_pkg::CLKSRC_REF));
    repeat (10 * 2 * REF_HALF) begin  // ten ref periods
      @(negedge clk);
      // rise pulse lands while ref_clk is still high, fall pulse while low
      if (fc_events[periph_pkg::FC_EVT_REF_RISE] && ref_clk) rise_evts++;
      if (fc_events[periph_pkg::FC_EVT_REF_FALL] && !ref_clk) fall_evts++;
    end
    edges = ref_rises - rises0;
    apb_read(reg_addr(3, periph_pkg::REG_COUNT), data, err);
    apb_write(reg_addr(3, periph_pkg::REG_CTRL), 32'h0);
    check_true(int'(data) >= edges - 1 && int'(data) <= edges + 1,
               $sformatf("ch3 COUNT is %0d after %0d ref edges", data, edges));
    check_true(rise_evts >= 9 && rise_evts <= 11,
               $sformatf("ref rise line gave %0d pulses in ten ref periods", rise_evts));
    check_true(fall_evts >= 9 && fall_evts <= 11,
               $sformatf("ref fall line gave %0d pulses in ten ref periods", fall_evts));
    // ref rise and fall must both be pending by now
    apb_read(reg_addr(periph_pkg::REGION_EVENT, periph_pkg::REG_PENDING), data, err);
    check_value("PENDING[5:4]", 32'(data[5:4]), 32'h3);
    @(negedge clk);
    check_value("summary, all masked", 32'(fc_events[periph_pkg::FC_EVT_SUMMARY]), 0);
    apb_write(reg_addr(periph_pkg::REGION_EVENT, periph_pkg::REG_MASK), 32'h10);
    repeat (2) @(negedge clk);
    check_value("summary, rise unmasked", 32'(fc_events[periph_pkg::FC_EVT_SUMMARY]), 1);
    @(negedge clk);
    ref_en = 1'b0;
    repeat (6) @(posedge clk);  // let sync pulses drain
    apb_write(reg_addr(periph_pkg::REGION_EVENT, periph_pkg::REG_PENDING), 32'h3f);
    read_check("PENDING cleared", reg_addr(periph_pkg::REGION_EVENT, periph_pkg::REG_PENDING), 0);
    @(negedge clk);
    check_value("summary after clear", 32'(fc_events[periph_pkg::FC_EVT_SUMMARY]), 0);
    apb_write(reg_addr(periph_pkg::REGION_EVENT, periph_pkg::REG_MASK), 32'h0);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    ref_clk = 1'b0;
    repeat (3) @(posedge clk);  // reset for 3 cycles
    #2;
    rst = 1'b0;
    test_reset_state();
    test_register_access();
    test_free_pwm();
    test_oneshot();
    test_ref_tick_pending();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
periph_pkg.sv
reg_bus_if.sv
periph_bus_decoder.sv
ref_clk_sync.sv
timer_channel.sv
soc_event_unit.sv
soc_peripherals.sv
tb_soc_peripherals.sv
